// ==== Makefile ====
# Verilator flow for the snoop-response combiner

VERILATOR  ?= verilator
TOP        ?= tb_snoop_resp
RTL_TOP    ?= snoop_resp_top
FILELIST   ?= vlog.f
OBJ_DIR    ?= obj_dir
SIM_FLAGS  ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The simulator exits non-zero on $fatal, so make fails with it
sim: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_snoop_resp.sv ====
`include "snoop_defs.svh"

module tb_snoop_resp;

    localparam int NUM_TXN   = 200;
    localparam int MAX_CYCLE = NUM_TXN * 64;    // Per-transaction budget of 64 cycles

    logic                                 clk_i;
    logic                                 rst_ni;
    logic                [`NUM_SNOOP-1:0] cr_valids_i;
    logic                [`NUM_SNOOP-1:0] cr_readies_o;
    snoop_pkg::cr_chan_t [`NUM_SNOOP-1:0] cr_chans_i;
    logic                [`NUM_SNOOP-1:0] cd_valids_i;
    logic                [`NUM_SNOOP-1:0] cd_readies_o;
    snoop_pkg::cd_chan_t [`NUM_SNOOP-1:0] cd_chans_i;
    logic                [`NUM_SNOOP-1:0] oup_sel_i;
    logic                                 oup_sel_valid_i;
    logic                                 oup_sel_ready_o;
    logic                                 cr_valid_o;
    logic                                 cr_ready_i;
    snoop_pkg::cr_chan_t                  cr_chan_o;
    logic                                 cd_valid_o;
    logic                                 cd_ready_i;
    snoop_pkg::cd_chan_t                  cd_chan_o;

    // Snooper drivers and reference model
    logic [31:0]           rng_state;
    snoop_pkg::cr_chan_t   flags [`NUM_SNOOP];
    int                    cr_wait [`NUM_SNOOP];
    int                    blen [`NUM_SNOOP];
    int                    beat [`NUM_SNOOP];
    logic [`NUM_SNOOP-1:0] cr_pend;             // CR not yet accepted
    logic [`NUM_SNOOP-1:0] cd_pend;             // Burst not yet fully consumed
    logic [`NUM_SNOOP-1:0] mask;
    snoop_pkg::cr_chan_t   exp_cr;
    int                    txn_no;
    int                    cycles;
    int                    cr_out;
    int                    fwd_cnt;
    int                    fwd_src;
    int                    first_dt;            // Lowest data snooper, -1 if none
    logic                  in_txn;
    logic                  fwd_done;
    logic                  directed;
    logic                  go_all;

    snoop_resp_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 16;                 // Upper bits have the longer period
    endfunction

    // Snooper index, transaction number and beat number
    function automatic logic [`DATA_W-1:0] beat_word(int src, int txn, int idx);
        return {src[7:0], txn[15:0], idx[7:0]};
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch in %s", what);
        end
    endtask

    task automatic start_txn();
        directed = (txn_no % 4) == 3;           // Every fourth one races all bursts
        mask     = `NUM_SNOOP'(next_rand());
        exp_cr   = '0;
        first_dt = -1;
        for (int j = `NUM_SNOOP - 1; j >= 0; j--) begin
            flags[j] = 5'(next_rand());
            if (directed) flags[j].DataTransfer = 1'b1;
            cr_wait[j] = int'(next_rand() % 8);
            blen[j]    = int'(next_rand() % 4) + 1;
            beat[j]    = 0;
            cr_pend[j] = mask[j];
            cd_pend[j] = mask[j] && flags[j].DataTransfer;
            if (mask[j]) exp_cr = exp_cr | flags[j];
            if (cd_pend[j]) first_dt = j;
        end
        cr_out          = 0;
        fwd_cnt         = 0;
        fwd_done        = 1'b0;
        oup_sel_i       <= mask;
        oup_sel_valid_i <= 1'b1;
    endtask

    task automatic check_outputs();
        if (cr_valid_o && cr_ready_i) begin
            check_value(32'(cr_pend), 0, "combined CR before all snooper CRs");
            check_value(32'(cr_out), 0, "second combined CR in one transaction");
            check_value(32'(cr_chan_o), 32'(exp_cr), "combined CR flags");
            cr_out++;
        end
        if (cd_valid_o && cd_ready_i) begin
            if (fwd_cnt == 0) begin
                fwd_src = int'(cd_chan_o.data[`DATA_W-1 -: 8]);
                check_value(32'(fwd_src < `NUM_SNOOP), 1, "forwarded source index");
                check_value(32'(mask[fwd_src] && flags[fwd_src].DataTransfer), 1,
                            "forwarded source sent DataTransfer");
                if (directed) check_value(fwd_src, first_dt, "first responder");
            end
            check_value(32'(fwd_done), 0, "beat after the forwarded burst ended");
            check_value(cd_chan_o.data, beat_word(fwd_src, txn_no, fwd_cnt),
                        "forwarded beat data");
            check_value(32'(cd_chan_o.last), 32'(fwd_cnt == blen[fwd_src] - 1),
                        "forwarded last flag");
            fwd_done = cd_chan_o.last;
            fwd_cnt++;
        end
    endtask

    task automatic step_cr(int j);
        if (cr_valids_i[j] && cr_readies_o[j]) begin
            check_value(32'(in_txn), 1, "CR taken outside a transaction");
            cr_pend[j]     = 1'b0;
            cr_valids_i[j] <= 1'b0;
        end else if (cr_pend[j] && !cr_valids_i[j]) begin
            if (cr_wait[j] == 0) begin
                cr_valids_i[j] <= 1'b1;
                cr_chans_i[j]  <= flags[j];
            end else begin
                cr_wait[j]--;
            end
        end
    endtask

    task automatic step_cd(int j);
        if (cd_valids_i[j] && cd_readies_o[j]) begin
            if (beat[j] == blen[j] - 1) cd_pend[j] = 1'b0;
            beat[j]++;
        end
        if (!cd_valids_i[j] || cd_readies_o[j]) begin     // A stalled beat stays put
            if (cd_pend[j] && !cr_pend[j] && (!directed || go_all) &&
                ((directed && beat[j] == 0) || next_rand() % 4 != 0)) begin
                cd_valids_i[j] <= 1'b1;
                cd_chans_i[j]  <= '{data: beat_word(j, txn_no, beat[j]),
                                    last: beat[j] == blen[j] - 1};
            end else begin
                cd_valids_i[j] <= 1'b0;
            end
        end
    endtask

    initial begin
        rng_state       = 32'hcda0_32c5;
        rst_ni          = 1'b0;
        cr_valids_i     = '0;
        cr_chans_i      = '0;
        cd_valids_i     = '0;
        cd_chans_i      = '0;
        oup_sel_i       = '0;
        oup_sel_valid_i = 1'b0;
        cr_ready_i      = 1'b0;
        cd_ready_i      = 1'b0;
        cr_pend         = '0;
        cd_pend         = '0;
        mask            = '0;
        in_txn          = 1'b0;
        txn_no          = 0;
        cycles          = 0;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);
        check_value(32'(oup_sel_ready_o), 1, "mask ready after reset");
        check_value(32'(cr_valid_o), 0, "combined CR valid after reset");
        check_value(32'(cd_valid_o), 0, "forwarded CD valid after reset");
        check_value(32'({cr_readies_o, cd_readies_o}), 0, "snooper readies after reset");
        while (txn_no < NUM_TXN) begin
            cycles++;
            if (cycles > MAX_CYCLE) begin
                $display("*** FAILED ***");
                $fatal(1, "Timeout: only %0d transactions done in %0d cycles",
                       txn_no, MAX_CYCLE);
            end
            check_outputs();
            for (int j = 0; j < `NUM_SNOOP; j++) step_cr(j);
            go_all = cr_pend == '0;
            for (int j = 0; j < `NUM_SNOOP; j++) step_cd(j);
            if (oup_sel_valid_i && oup_sel_ready_o) begin
                oup_sel_valid_i <= 1'b0;
                in_txn          = 1'b1;
            end else if (in_txn && oup_sel_ready_o) begin    // Back to idle
                check_value(32'(cr_out), 1, "combined CR count");
                check_value(32'(cr_pend | cd_pend), 0, "snooper left stalled");
                check_value(32'(fwd_done), 32'(first_dt >= 0), "forwarded burst complete");
                in_txn = 1'b0;
                txn_no++;
            end else if (!in_txn && !oup_sel_valid_i) begin
                start_txn();
            end
            cr_ready_i <= next_rand() % 4 != 0;
            cd_ready_i <= next_rand() % 4 != 0;
            @(posedge clk_i);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== logic/cd_first_select.sv ====
`include "snoop_defs.svh"

module cd_first_select (
    input  logic                clk_i,
    input  logic                rst_ni,

    snoop_port_if.cd_mp         snp,
    snoop_txn_if.cd_mp          txn,

    output logic                cd_valid_o,
    input  logic                cd_ready_i,
    output snoop_pkg::cd_chan_t cd_chan_o
);

    logic [`NUM_SNOOP-1:0]   eligible;
    logic [`NUM_SNOOP-1:0]   cd_ready;
    logic [`NUM_SNOOP-1:0]   last_fire;
    logic [`NUM_SNOOP-1:0]   fin_q;
    logic [`NUM_SNOOP-1:0]   fin_d;
    logic [`SNOOP_IDX_W-1:0] fr_q;
    logic [`SNOOP_IDX_W-1:0] cand_idx;
    logic [`SNOOP_IDX_W-1:0] fr_sel;
    snoop_pkg::fr_state_e    state_q;
    logic                    cand_found;
    logic                    fr_hit;
    logic                    all_fin;
    logic                    cr_seen_q;

    // Snoopers whose burst is announced but not yet finished
    assign eligible = {`NUM_SNOOP{txn.active}} & txn.sel_mask & txn.dt_mask & ~fin_q;

    // Lowest eligible snooper that is offering a beat
    always_comb begin
        cand_idx   = '0;
        cand_found = 1'b0;
        for (int i = `NUM_SNOOP - 1; i >= 0; i--) begin
            if (eligible[i] && snp.cd_valid[i]) begin
                cand_idx   = i[`SNOOP_IDX_W-1:0];
                cand_found = 1'b1;
            end
        end
    end

    assign fr_hit = (state_q == snoop_pkg::FR_LOCKED) || cand_found;
    assign fr_sel = (state_q == snoop_pkg::FR_LOCKED) ? fr_q : cand_idx;

    // First responder sees output back-pressure, everyone else is drained
    always_comb begin
        for (int i = 0; i < `NUM_SNOOP; i++) begin
            if (fr_hit && fr_sel == i[`SNOOP_IDX_W-1:0]) begin
                cd_ready[i] = eligible[i] && cd_ready_i;
            end else begin
                cd_ready[i] = eligible[i];
            end
            last_fire[i] = snp.cd_valid[i] && cd_ready[i] && snp.cd_chan[i].last;
        end
    end

    assign snp.cd_ready = cd_ready;

    assign cd_valid_o = fr_hit && eligible[fr_sel] && snp.cd_valid[fr_sel];
    assign cd_chan_o  = snp.cd_chan[fr_sel];

    assign fin_d   = fin_q | last_fire;
    assign all_fin = (txn.sel_mask & txn.dt_mask & ~fin_d) == '0;

    // dt_mask is final once the combined CR has gone out
    assign txn.cd_done = txn.active && (cr_seen_q || txn.cr_done) && all_fin;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= snoop_pkg::FR_FREE;
            fr_q      <= '0;
            fin_q     <= '0;
            cr_seen_q <= 1'b0;
        end else if (!txn.active) begin
            state_q   <= snoop_pkg::FR_FREE;    // Lock spans one transaction
            fin_q     <= '0;
            cr_seen_q <= 1'b0;
        end else begin
            fin_q <= fin_d;
            if (state_q == snoop_pkg::FR_FREE && cand_found) begin
                state_q <= snoop_pkg::FR_LOCKED;
                fr_q    <= cand_idx;
            end
            if (txn.cr_done) begin
                cr_seen_q <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/cr_combine.sv ====
`include "snoop_defs.svh"

module cr_combine (
    input  logic                clk_i,
    input  logic                rst_ni,

    snoop_port_if.cr_mp         snp,
    snoop_txn_if.cr_mp          txn,

    output logic                cr_valid_o,
    input  logic                cr_ready_i,
    output snoop_pkg::cr_chan_t cr_chan_o
);

    logic                [`NUM_SNOOP-1:0] captured_q;
    logic                [`NUM_SNOOP-1:0] cr_ready;
    logic                [`NUM_SNOOP-1:0] cr_fire;
    snoop_pkg::cr_chan_t [`NUM_SNOOP-1:0] cr_q;
    logic                                 sent_q;
    logic                                 all_captured;

    // Each selected snooper is accepted exactly once
    always_comb begin
        for (int i = 0; i < `NUM_SNOOP; i++) begin
            cr_ready[i] = txn.active && txn.sel_mask[i] && !captured_q[i];
            cr_fire[i]  = cr_ready[i] && snp.cr_valid[i];
        end
    end

    assign snp.cr_ready = cr_ready;

    assign all_captured = (captured_q & txn.sel_mask) == txn.sel_mask;

    // Valid from the cycle after the final capture until accepted
    assign cr_valid_o  = txn.active && all_captured && !sent_q;
    assign txn.cr_done = cr_valid_o && cr_ready_i;

    always_comb begin
        for (int i = 0; i < `NUM_SNOOP; i++) begin
            txn.dt_mask[i] = captured_q[i] && cr_q[i].DataTransfer;
        end
    end

    // OR of all captured flags
    always_comb begin
        cr_chan_o = '0;
        for (int i = 0; i < `NUM_SNOOP; i++) begin
            if (captured_q[i]) begin
                cr_chan_o.WasUnique    |= cr_q[i].WasUnique;
                cr_chan_o.IsShared     |= cr_q[i].IsShared;
                cr_chan_o.PassDirty    |= cr_q[i].PassDirty;
                cr_chan_o.Error        |= cr_q[i].Error;
                cr_chan_o.DataTransfer |= cr_q[i].DataTransfer;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            captured_q <= '0;
            sent_q     <= 1'b0;
        end else if (!txn.active) begin
            captured_q <= '0;               // Cleared while the controller closes
            sent_q     <= 1'b0;
        end else begin
            captured_q <= captured_q | cr_fire;
            if (txn.cr_done) begin
                sent_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < `NUM_SNOOP; i++) begin
            if (cr_fire[i]) begin
                cr_q[i] <= snp.cr_chan[i];
            end
        end
    end

endmodule

// ==== logic/snoop_defs.svh ====
`ifndef SNOOP_DEFS_SVH
`define SNOOP_DEFS_SVH

// Number of snoopers behind the combiner
`define NUM_SNOOP 4

// Width of one CD data beat
`define DATA_W 32

// Width of a snooper index
`define SNOOP_IDX_W $clog2(`NUM_SNOOP)

`endif

// ==== logic/snoop_pkg.sv ====
`include "snoop_defs.svh"

package snoop_pkg;

    // Snoop control response flags
    typedef struct packed {
        logic WasUnique;                // Line was held unique
        logic IsShared;                 // Snooper keeps a copy
        logic PassDirty;                // Responsibility for dirty data moves
        logic Error;                    // Snooper reported an error
        logic DataTransfer;             // A CD burst follows
    } cr_chan_t;

    // Snoop data beat
    typedef struct packed {
        logic [`DATA_W-1:0] data;
        logic               last;       // Final beat of the burst
    } cd_chan_t;

    // Transaction controller states
    typedef enum logic [1:0] {
        TXN_IDLE   = 2'd0,
        TXN_ACTIVE = 2'd1,
        TXN_CLOSE  = 2'd2
    } txn_state_e;

    // First-responder tracking
    typedef enum logic {
        FR_FREE   = 1'b0,
        FR_LOCKED = 1'b1
    } fr_state_e;

endpackage

// ==== logic/snoop_port_if.sv ====
`include "snoop_defs.svh"

interface snoop_port_if;

    // Control responses, one lane per snooper
    logic                [`NUM_SNOOP-1:0] cr_valid;
    logic                [`NUM_SNOOP-1:0] cr_ready;
    snoop_pkg::cr_chan_t [`NUM_SNOOP-1:0] cr_chan;

    // Data bursts, one lane per snooper
    logic                [`NUM_SNOOP-1:0] cd_valid;
    logic                [`NUM_SNOOP-1:0] cd_ready;
    snoop_pkg::cd_chan_t [`NUM_SNOOP-1:0] cd_chan;

    // CR side as seen by the combiner
    modport cr_mp (
        input  cr_valid,
        input  cr_chan,
        output cr_ready
    );

    // CD side as seen by the burst selector
    modport cd_mp (
        input  cd_valid,
        input  cd_chan,
        output cd_ready
    );

endinterface

// ==== logic/snoop_resp_top.sv ====
`include "snoop_defs.svh"

module snoop_resp_top (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,

    // Per-snooper control responses
    input  logic                [`NUM_SNOOP-1:0] cr_valids_i,
    output logic                [`NUM_SNOOP-1:0] cr_readies_o,
    input  snoop_pkg::cr_chan_t [`NUM_SNOOP-1:0] cr_chans_i,

    // Per-snooper data bursts
    input  logic                [`NUM_SNOOP-1:0] cd_valids_i,
    output logic                [`NUM_SNOOP-1:0] cd_readies_o,
    input  snoop_pkg::cd_chan_t [`NUM_SNOOP-1:0] cd_chans_i,

    // Snooper selection for the next transaction
    input  logic                [`NUM_SNOOP-1:0] oup_sel_i,
    input  logic                                 oup_sel_valid_i,
    output logic                                 oup_sel_ready_o,

    // Combined CR towards the requester
    output logic                                 cr_valid_o,
    input  logic                                 cr_ready_i,
    output snoop_pkg::cr_chan_t                  cr_chan_o,

    // Forwarded CD burst towards the requester
    output logic                                 cd_valid_o,
    input  logic                                 cd_ready_i,
    output snoop_pkg::cd_chan_t                  cd_chan_o
);

    snoop_port_if snp ();
    snoop_txn_if  txn ();

    // Snooper lanes onto the port bundle
    assign snp.cr_valid = cr_valids_i;
    assign snp.cr_chan  = cr_chans_i;
    assign cr_readies_o = snp.cr_ready;

    assign snp.cd_valid = cd_valids_i;
    assign snp.cd_chan  = cd_chans_i;
    assign cd_readies_o = snp.cd_ready;

    snoop_txn_ctrl i_txn_ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .oup_sel_i       (oup_sel_i),
        .oup_sel_valid_i (oup_sel_valid_i),
        .oup_sel_ready_o (oup_sel_ready_o),
        .txn             (txn.ctrl_mp)
    );

    cr_combine i_cr_combine (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .snp        (snp.cr_mp),
        .txn        (txn.cr_mp),
        .cr_valid_o (cr_valid_o),
        .cr_ready_i (cr_ready_i),
        .cr_chan_o  (cr_chan_o)
    );

    cd_first_select i_cd_first_select (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .snp        (snp.cd_mp),
        .txn        (txn.cd_mp),
        .cd_valid_o (cd_valid_o),
        .cd_ready_i (cd_ready_i),
        .cd_chan_o  (cd_chan_o)
    );

endmodule

// ==== logic/snoop_txn_ctrl.sv ====
`include "snoop_defs.svh"

module snoop_txn_ctrl (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic [`NUM_SNOOP-1:0] oup_sel_i,
    input  logic                  oup_sel_valid_i,
    output logic                  oup_sel_ready_o,

    snoop_txn_if.ctrl_mp          txn
);

    snoop_pkg::txn_state_e state_q;
    logic [`NUM_SNOOP-1:0] mask_q;
    logic                  cr_seen_q;
    logic                  cd_seen_q;
    logic                  cr_seen;
    logic                  cd_seen;

    assign oup_sel_ready_o = (state_q == snoop_pkg::TXN_IDLE);

    assign txn.active   = (state_q == snoop_pkg::TXN_ACTIVE);
    assign txn.sel_mask = mask_q;

    // Done results may arrive in either order
    assign cr_seen = cr_seen_q || txn.cr_done;
    assign cd_seen = cd_seen_q || txn.cd_done;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= snoop_pkg::TXN_IDLE;
            mask_q    <= '0;
            cr_seen_q <= 1'b0;
            cd_seen_q <= 1'b0;
        end else begin
            case (state_q)
                snoop_pkg::TXN_IDLE: begin
                    cr_seen_q <= 1'b0;
                    cd_seen_q <= 1'b0;
                    if (oup_sel_valid_i) begin
                        mask_q  <= oup_sel_i;
                        state_q <= snoop_pkg::TXN_ACTIVE;
                    end
                end
                snoop_pkg::TXN_ACTIVE: begin
                    cr_seen_q <= cr_seen;
                    cd_seen_q <= cd_seen;
                    if (cr_seen && cd_seen) begin
                        state_q <= snoop_pkg::TXN_CLOSE;
                    end
                end
                // One cycle with active low lets both blocks clear
                snoop_pkg::TXN_CLOSE: state_q <= snoop_pkg::TXN_IDLE;
                default:              state_q <= snoop_pkg::TXN_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/snoop_txn_if.sv ====
`include "snoop_defs.svh"

interface snoop_txn_if;

    logic                  active;      // Transaction in flight
    logic [`NUM_SNOOP-1:0] sel_mask;    // Snoopers taking part
    logic [`NUM_SNOOP-1:0] dt_mask;     // Captured DataTransfer bits
    logic                  cr_done;     // Combined CR accepted
    logic                  cd_done;     // All bursts consumed

    modport ctrl_mp (
        output active,
        output sel_mask,
        input  dt_mask,
        input  cr_done,
        input  cd_done
    );

    modport cr_mp (
        input  active,
        input  sel_mask,
        output dt_mask,
        output cr_done
    );

    // The burst side also watches cr_done, after which dt_mask is final
    modport cd_mp (
        input  active,
        input  sel_mask,
        input  dt_mask,
        input  cr_done,
        output cd_done
    );

endinterface

// ==== vlog.f ====
+incdir+logic
logic/snoop_pkg.sv
logic/snoop_port_if.sv
logic/snoop_txn_if.sv
logic/cr_combine.sv
logic/cd_first_select.sv
logic/snoop_txn_ctrl.sv
logic/snoop_resp_top.sv
bench/tb_snoop_resp.sv
